// File: source/lsuPkg.sv
package lsuPkg;

    // widths shared by every block of the memory side
    localparam int dataWidth = 32;      // machine word
    localparam int addrWidth = 9;       // 512-word ram
    localparam int regIndexWidth = 4;   // 16 registers
    localparam int constWidth = 19;     // immediate field of the instruction

    // memory opcodes; every other code is legal and completes as a no-op
    typedef enum logic [4:0] {
        opLd  = 5'd0,   // R[ra] <- mem[ea]
        opLdi = 5'd1,   // R[ra] <- ea
        opSt  = 5'd2    // mem[ea] <- R[ra]
    } opcode_t;

    typedef logic [regIndexWidth-1:0] regIndex_t;  // register number
    typedef logic [addrWidth-1:0] ramAddr_t;       // low bits of the effective address

    // instruction layout, msb first
    typedef struct packed {
        opcode_t opcode;            // [31:27]
        regIndex_t ra;              // [26:23] target or store source
        regIndex_t rb;              // [22:19] base, zero means no base
        logic [constWidth-1:0] c;   // [18:0] signed constant
    } instFields_t;

    // one word seen either raw (as queued) or split into fields (as decoded)
    typedef union packed {
        logic [dataWidth-1:0] raw;
        instFields_t fields;
    } instWord_t;

    // a completion record carries the opcode, ra and one data word:
    //   ld    data read from ram
    //   ldi   effective address
    //   st    value stored
    //   other zero

endpackage

// File: source/ramBus.sv
`timescale 1ns/1ps

// single-port ram access between the unit and the memory
interface ramBus;
    import lsuPkg::*;

    ramAddr_t address;                  // word address, low bits of ea
    logic [dataWidth-1:0] writeData;    // store data
    logic writeEnable;                  // one-cycle store strobe
    logic readEnable;                   // one-cycle load strobe
    logic [dataWidth-1:0] readData;     // valid the cycle after readEnable

    // unit side
    modport master (
        output address,
        output writeData,
        output writeEnable,
        output readEnable,
        input  readData
    );

    // memory side
    modport slave (
        input  address,
        input  writeData,
        input  writeEnable,
        input  readEnable,
        output readData
    );

endinterface

// File: source/memRam.sv
`timescale 1ns/1ps

module memRam #(
    parameter int Depth = 512
) (
    input logic clk,
    ramBus.slave bus
);
    import lsuPkg::*;

    // contents power up as zero
    logic [dataWidth-1:0] mem [Depth] = '{default: '0};

    // write port
    always_ff @(posedge clk) begin
        if (bus.writeEnable) begin
            mem[bus.address] <= bus.writeData;
        end
    end

    // registered read that holds its last value while readEnable is low
    always_ff @(posedge clk) begin
        if (bus.readEnable) begin
            bus.readData <= mem[bus.address];   // old contents on a same-address write
        end
    end

endmodule

// File: source/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic clk,
    input  logic reset,
    input  lsuPkg::regIndex_t readIndexA,
    input  lsuPkg::regIndex_t readIndexB,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB,
    input  logic writeEnable,
    input  lsuPkg::regIndex_t writeIndex,
    input  logic [31:0] writeData
);
    import lsuPkg::*;

    localparam int NumRegs = 1 << regIndexWidth;   // 16 entries

    logic [31:0] regs [NumRegs];

    // r0 is a plain register here; the base-zero rule lives in the unit
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;  // every register starts cleared
            end
        end else if (writeEnable) begin
            regs[writeIndex] <= writeData;
        end
    end

    // two asynchronous read ports
    assign readDataA = regs[readIndexA];  // store source
    assign readDataB = regs[readIndexB];  // base

endmodule

// File: source/instQueue.sv
`timescale 1ns/1ps

module instQueue #(
    parameter int Depth = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic instValid,
    input  lsuPkg::instWord_t instWord,
    output logic headValid,
    output lsuPkg::instWord_t headWord,
    input  logic pop,
    output logic instCredit
);
    import lsuPkg::*;

    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    instWord_t slots [Depth];           // circular buffer storage
    logic [PtrWidth-1:0] wrPtr;         // next free slot
    logic [PtrWidth-1:0] rdPtr;         // current head
    logic [CountWidth-1:0] count;       // words held

    // wrap explicitly so a depth that is not a power of two still works
    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // payload store
    always_ff @(posedge clk) begin
        if (instValid) begin
            slots[wrPtr] <= instWord;
        end
    end

    // pointers and occupancy
    // the sender's credits keep count from passing Depth
    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (instValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + CountWidth'(instValid) - CountWidth'(pop);  // push and pop may coincide
        end
    end

    assign headValid = (count != '0);   // word pushed in t shows up in t+1
    assign headWord = slots[rdPtr];

    // one credit per word taken, straight from the unit's pop flop
    // and in the same cycle as the pop
    assign instCredit = pop;

endmodule

// File: source/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit #(
    parameter int ResultCredits = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic headValid,
    input  lsuPkg::instWord_t headWord,
    output logic pop,
    ramBus.master ram,
    output lsuPkg::regIndex_t readIndexA,
    output lsuPkg::regIndex_t readIndexB,
    input  logic [31:0] readDataA,
    input  logic [31:0] readDataB,
    output logic regWriteEnable,
    output lsuPkg::regIndex_t regWriteIndex,
    output logic [31:0] regWriteData,
    output logic resValid,
    output lsuPkg::opcode_t resOp,
    output lsuPkg::regIndex_t resReg,
    output logic [31:0] resData,
    input  logic resCredit
);
    import lsuPkg::*;

    localparam logic [1:0] stateIdle = 2'd0;      // waiting or popping
    localparam logic [1:0] stateExecute = 2'd1;   // ram or register action with non-load records
    localparam logic [1:0] stateLoadWait = 2'd2;  // ram read data returns
    localparam int CreditWidth = $clog2(ResultCredits + 1);

    logic [1:0] state;
    logic [CreditWidth-1:0] credits;    // result records we may still send
    instFields_t inst;                  // instruction in flight
    logic [dataWidth-1:0] effAddr;      // latched effective address
    logic [dataWidth-1:0] storeData;    // latched R[ra]
    logic [dataWidth-1:0] headBase;
    logic [dataWidth-1:0] headEffAddr;
    logic isLoad;
    logic isLoadImm;
    logic isStore;

    // registers are read straight off the queue head during the pop cycle;
    // only one instruction is in flight, so no write can be pending
    assign readIndexA = headWord.fields.ra;
    assign readIndexB = headWord.fields.rb;

    // rb = 0 means no base rather than R0
    assign headBase = (headWord.fields.rb == '0) ? '0 : readDataB;
    assign headEffAddr = {{(dataWidth - constWidth){headWord.fields.c[constWidth-1]}},
                          headWord.fields.c} + headBase;

    // control FSM; pop is registered and lasts exactly one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stateIdle;
            pop <= 1'b0;
        end else begin
            pop <= 1'b0;
            case (state)
                stateIdle: begin
                    if (pop) begin
                        state <= stateExecute;  // head taken at this edge
                    end else if (headValid && credits != '0) begin
                        pop <= 1'b1;            // head taken next while a credit is left
                    end
                end
                stateExecute: begin
                    state <= isLoad ? stateLoadWait : stateIdle;
                end
                stateLoadWait: begin
                    state <= stateIdle;
                end
                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

    // instruction payload latched on pop
    always_ff @(posedge clk) begin
        if (pop) begin
            inst <= headWord.fields;
            effAddr <= headEffAddr;
            storeData <= readDataA;
        end
    end

    // result credits spent per record and returned per resCredit pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CreditWidth'(ResultCredits);
        end else begin
            credits <= credits + CreditWidth'(resCredit) - CreditWidth'(resValid);
        end
    end

    assign isLoad = (inst.opcode == opLd);
    assign isLoadImm = (inst.opcode == opLdi);
    assign isStore = (inst.opcode == opSt);

    // ram access issued in the cycle after pop
    assign ram.address = effAddr[addrWidth-1:0];  // ea truncated to 9 bits
    assign ram.writeData = storeData;
    assign ram.writeEnable = (state == stateExecute) && isStore;
    assign ram.readEnable = (state == stateExecute) && isLoad;

    // register write lands with the record
    assign regWriteEnable = ((state == stateExecute) && isLoadImm) || (state == stateLoadWait);
    assign regWriteIndex = inst.ra;
    assign regWriteData = isLoad ? ram.readData : effAddr;

    // completion record
    assign resValid = ((state == stateExecute) && !isLoad) || (state == stateLoadWait);
    assign resOp = inst.opcode;
    assign resReg = inst.ra;

    always_comb begin
        case (inst.opcode)
            opLd: resData = ram.readData;
            opLdi: resData = effAddr;        // full 32-bit ea
            opSt: resData = storeData;
            default: resData = '0;           // no-op record
        endcase
    end

endmodule

// File: source/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem #(
    parameter int QueueDepth = 4,
    parameter int ResultCredits = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic instValid,
    input  logic [31:0] instWord,
    output logic instCredit,
    output logic resValid,
    output logic [4:0] resOp,
    output logic [3:0] resReg,
    output logic [31:0] resData,
    input  logic resCredit
);
    import lsuPkg::*;

    // queue head toward the unit
    logic headValid;
    instWord_t headWord;
    logic pop;

    // register file ports
    regIndex_t readIndexA;
    regIndex_t readIndexB;
    logic [dataWidth-1:0] readDataA;
    logic [dataWidth-1:0] readDataB;
    logic regWriteEnable;
    regIndex_t regWriteIndex;
    logic [dataWidth-1:0] regWriteData;

    ramBus ramIf ();  // unit to ram

    instQueue #(
        .Depth(QueueDepth)
    ) queue (
        .clk(clk),
        .reset(reset),
        .instValid(instValid),
        .instWord(instWord),            // raw word into the union
        .headValid(headValid),
        .headWord(headWord),
        .pop(pop),
        .instCredit(instCredit)
    );

    loadStoreUnit #(
        .ResultCredits(ResultCredits)
    ) unit (
        .clk(clk),
        .reset(reset),
        .headValid(headValid),
        .headWord(headWord),
        .pop(pop),
        .ram(ramIf.master),
        .readIndexA(readIndexA),
        .readIndexB(readIndexB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .regWriteEnable(regWriteEnable),
        .regWriteIndex(regWriteIndex),
        .regWriteData(regWriteData),
        .resValid(resValid),
        .resOp(resOp),
        .resReg(resReg),
        .resData(resData),
        .resCredit(resCredit)
    );

    regFile regs (
        .clk(clk),
        .reset(reset),
        .readIndexA(readIndexA),
        .readIndexB(readIndexB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .writeEnable(regWriteEnable),
        .writeIndex(regWriteIndex),
        .writeData(regWriteData)
    );

    memRam #(
        .Depth(1 << addrWidth)          // full 9-bit address space
    ) ram (
        .clk(clk),
        .bus(ramIf.slave)
    );

endmodule

// File: tb/lsuModel.svh
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

// one expected completion record, tagged with the test that sent it
typedef struct {
    string testName;
    opcode_t op;
    regIndex_t rg;
    logic [dataWidth-1:0] data;
} expRecord_t;

logic [dataWidth-1:0] shadowReg [16] = '{default: '0};               // register file copy
logic [dataWidth-1:0] shadowMem [1 << addrWidth] = '{default: '0};   // ram copy
int errorCount = 0;
int checkCount = 0;

// applies one instruction to the shadow state and returns its record
function automatic expRecord_t expectResult(input string testName, input instWord_t w);
    expRecord_t r;
    logic [dataWidth-1:0] base;
    logic [dataWidth-1:0] ea;
    base = (w.fields.rb == 0) ? '0 : shadowReg[w.fields.rb];  // rb of zero means no base
    ea = 32'($signed(w.fields.c)) + base;
    r.testName = testName;
    r.op = w.fields.opcode;
    r.rg = w.fields.ra;
    case (w.fields.opcode)
        opLd: begin
            r.data = shadowMem[ea[addrWidth-1:0]];
            shadowReg[w.fields.ra] = r.data;
        end
        opLdi: begin
            r.data = ea;                                // whole 32-bit address
            shadowReg[w.fields.ra] = ea;
        end
        opSt: begin
            r.data = shadowReg[w.fields.ra];
            shadowMem[ea[addrWidth-1:0]] = r.data;      // only low address bits count
        end
        default: r.data = '0;                           // no state change
    endcase
    return r;
endfunction

task automatic checkOp(input string testName, input opcode_t expected, input opcode_t actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("[FAIL] %s: resOp expected %0d, actual %0d", testName, expected, actual);
    end
endtask

task automatic checkReg(input string testName, input regIndex_t expected,
                        input regIndex_t actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("[FAIL] %s: resReg expected %0d, actual %0d", testName, expected, actual);
    end
endtask

task automatic checkData(input string testName, input logic [dataWidth-1:0] expected,
                         input logic [dataWidth-1:0] actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("[FAIL] %s: resData expected %08h, actual %08h", testName, expected, actual);
    end
endtask

`endif

// File: tb/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb;
    import lsuPkg::*;
    `include "lsuModel.svh"

    localparam int QueueDepth = 4;
    localparam int ResultCredits = 2;

    logic clk = 1'b0;
    logic reset;
    logic instValid;
    logic [31:0] instWord;
    logic instCredit;
    logic resValid;
    logic [4:0] resOp;
    regIndex_t resReg;
    logic [31:0] resData;
    logic resCredit;

    expRecord_t expQueue [$];       // records still owed by the DUT in order
    int senderCredits = QueueDepth;
    int wordsSent = 0;
    int creditPulses = 0;           // instCredit pulses seen
    int recordCount = 0;
    int owedCredits = 0;            // result credits the consumer has yet to return
    int cycleCount = 0;
    int testCount = 0;
    logic holdCredits = 1'b0;       // withhold resCredit entirely
    logic randomCreditDelay = 1'b0;

    memSubsystem #(
        .QueueDepth(QueueDepth),
        .ResultCredits(ResultCredits)
    ) dut (
        .clk(clk),
        .reset(reset),
        .instValid(instValid),
        .instWord(instWord),
        .instCredit(instCredit),
        .resValid(resValid),
        .resOp(resOp),
        .resReg(resReg),
        .resData(resData),
        .resCredit(resCredit)
    );

    always #4 clk = ~clk;   // 8 ns period

    function automatic instWord_t makeInst(input opcode_t op, input regIndex_t ra,
                                           input regIndex_t rb, input int c);
        instWord_t w;
        w.fields.opcode = op;
        w.fields.ra = ra;
        w.fields.rb = rb;
        w.fields.c = c[constWidth-1:0];   // keep the low 19 bits
        return w;
    endfunction

    // one word per cycle while the sender holds a credit
    task automatic sendInst(input string testName, input instWord_t w);
        @(posedge clk);
        while (senderCredits == 0) begin
            instValid <= 1'b0;
            @(posedge clk);
        end
        instValid <= 1'b1;
        instWord <= w.raw;
        senderCredits--;
        wordsSent++;
        expQueue.push_back(expectResult(testName, w));
    endtask

    task automatic sendIdle();
        @(posedge clk);
        instValid <= 1'b0;
    endtask

    // all records in and all result credits handed back
    task automatic waitDrain();
        while (expQueue.size() != 0 || owedCredits != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic finishTest(input string testName, input int errorsBefore);
        sendIdle();
        waitDrain();
        testCount++;
        $display("%s: done, %0d mismatches", testName, errorCount - errorsBefore);
    endtask

    // compare process sampling in the middle of the cycle
    always @(negedge clk) begin : monitorBlock
        expRecord_t exp;
        if (!reset) begin
            if (instCredit) begin
                creditPulses++;
                senderCredits++;
                if (senderCredits > QueueDepth) begin
                    errorCount++;
                    $display("instruction credit returned with no word outstanding");
                end
            end
            if (resValid) begin
                recordCount++;
                owedCredits++;
                if (expQueue.size() == 0) begin
                    errorCount++;
                    $display("completion record arrived with nothing expected");
                end else begin
                    exp = expQueue.pop_front();
                    checkOp(exp.testName, exp.op, opcode_t'(resOp));
                    checkReg(exp.testName, exp.rg, resReg);
                    checkData(exp.testName, exp.data, resData);
                end
            end
        end
    end

    // consumer hands result credits back, now or after a random wait
    always @(posedge clk) begin
        if (reset) begin
            resCredit <= 1'b0;
        end else if (owedCredits > 0 && !holdCredits &&
                     (!randomCreditDelay || $urandom_range(2) == 0)) begin
            resCredit <= 1'b1;
            owedCredits--;
        end else begin
            resCredit <= 1'b0;
        end
    end

    // budget of 20 cycles per word plus 200
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > 20 * wordsSent + 200) begin
            $display("timeout after %0d cycles, %0d records never arrived",
                     cycleCount, expQueue.size());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int errorsBefore;
        int recordsBefore;
        int sentBefore;
        int sel;
        opcode_t op;
        void'($urandom(69731));
        reset = 1'b1;
        instValid = 1'b0;
        instWord = '0;
        resCredit = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // ldi with and without a base, both constant signs
        errorsBefore = errorCount;
        sendInst("ldiRule", makeInst(opLdi, 1, 0, 100));
        sendInst("ldiRule", makeInst(opLdi, 2, 0, -5));
        sendInst("ldiRule", makeInst(opLdi, 3, 1, 20));
        sendInst("ldiRule", makeInst(opLdi, 4, 2, -3));
        sendInst("ldiRule", makeInst(opLdi, 5, 1, -100));
        sendInst("ldiRule", makeInst(opLdi, 6, 0, 'h3ffff));   // largest positive constant
        sendInst("ldiRule", makeInst(opLdi, 7, 0, 'h40000));   // most negative constant
        sendInst("ldiRule", makeInst(opLdi, 0, 0, 7));
        sendInst("ldiRule", makeInst(opLdi, 8, 0, 1));         // R0 = 7 must not act as base
        finishTest("ldiRule", errorsBefore);

        // store, then load back through other base/constant pairs
        errorsBefore = errorCount;
        sendInst("storeLoad", makeInst(opLdi, 9, 0, 'h12345));
        sendInst("storeLoad", makeInst(opSt, 9, 0, 10));
        sendInst("storeLoad", makeInst(opLd, 10, 0, 10));
        sendInst("storeLoad", makeInst(opLd, 11, 1, -90));     // 100 - 90
        sendInst("storeLoad", makeInst(opSt, 2, 0, 521));      // wraps to word 9
        sendInst("storeLoad", makeInst(opLd, 13, 0, 9));
        sendInst("storeLoad", makeInst(opLd, 14, 1, -91));
        sendInst("storeLoad", makeInst(opLd, 15, 0, -503));    // negative ea, low bits 9
        sendInst("storeLoad", makeInst(opLd, 12, 0, 11));      // untouched word reads zero
        finishTest("storeLoad", errorsBefore);

        // unknown codes, then loads and a store that expose any side effect
        errorsBefore = errorCount;
        sendInst("unknownOp", makeInst(opcode_t'(5'd3), 1, 0, 10));
        sendInst("unknownOp", makeInst(opcode_t'(5'd7), 9, 1, -90));
        sendInst("unknownOp", makeInst(opcode_t'(5'd31), 15, 0, 9));
        sendInst("unknownOp", makeInst(opLd, 4, 0, 10));
        sendInst("unknownOp", makeInst(opLd, 5, 0, 9));
        sendInst("unknownOp", makeInst(opSt, 1, 0, 30));       // R1 still 100
        finishTest("unknownOp", errorsBefore);

        // random mix with a jittery consumer
        errorsBefore = errorCount;
        randomCreditDelay <= 1'b1;
        for (int i = 0; i < 200; i++) begin
            sel = $urandom_range(3);
            op = (sel == 0) ? opLd : (sel == 1) ? opLdi : (sel == 2) ? opSt :
                 opcode_t'(5'($urandom_range(31, 3)));
            sendInst("randomMix", makeInst(op, regIndex_t'($urandom_range(15)),
                     regIndex_t'($urandom_range(15)), int'($urandom_range(64)) - 32));
        end
        finishTest("randomMix", errorsBefore);
        randomCreditDelay <= 1'b0;

        // no result credits back until the queue has filled
        errorsBefore = errorCount;
        holdCredits <= 1'b1;
        recordsBefore = recordCount;
        sentBefore = wordsSent;
        fork
            begin
                for (int i = 0; i < 10; i++) begin
                    sendInst("backPressure", makeInst(opLdi, regIndex_t'(i), 0, 3 * i + 1));
                end
            end
            begin
                repeat (40) @(posedge clk);
                if (recordCount - recordsBefore > ResultCredits) begin
                    errorCount++;
                    $display("more records sent than result credits allowed");
                end
                if (senderCredits != 0 ||
                    wordsSent - sentBefore != QueueDepth + ResultCredits) begin
                    errorCount++;
                    $display("instruction credits kept flowing with the queue full");
                end
                holdCredits <= 1'b0;
            end
        join
        finishTest("backPressure", errorsBefore);

        // every word sent must come back as one instruction credit
        errorsBefore = errorCount;
        if (creditPulses != wordsSent) begin
            errorCount++;
            $display("[FAIL] creditCount: instCredit pulses expected %0d, actual %0d",
                     wordsSent, creditPulses);
        end
        finishTest("creditCount", errorsBefore);

        $display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+tb
source/lsuPkg.sv
source/ramBus.sv
source/memRam.sv
source/regFile.sv
source/instQueue.sv
source/loadStoreUnit.sv
source/memSubsystem.sv
tb/memSubsystemTb.sv
